// ==== bench/execStage_chk.sv ====
`timescale 1ns/1ps

module execStage_chk
    import exec_pkg::*;
(
    input logic        Clk,
    input logic        rst,
    input logic        flush,
    input execResult_t res,
    input logic        busy
);

    // a single access is either a read or a write
    assert property (@(posedge Clk) disable iff (rst) !(res.memRead && res.memWrite))
        else $error("memRead and memWrite both set");

    assert property (@(posedge Clk) disable iff (rst) res.unaligned |-> res.byteEn == 4'b0000)
        else $error("unaligned access with byte enables set");

    assert property (@(posedge Clk) disable iff (rst) flush |=> !res.valid)
        else $error("result still valid after flush");

    assert property (@(posedge Clk) rst |=> !busy)
        else $error("busy set after reset");

endmodule

bind execStage execStage_chk u_execStage_chk (.*);

// ==== bench/execStage_tb.sv ====
`timescale 1ns/1ps
`include "exec_consts.svh"

module execStage_tb
    import exec_pkg::*;
();
    localparam int AluRounds = 6;
    localparam int MdRuns    = 16;
    // reset, alu, forwarding, memory, multi-cycle (40 per op plus hi/lo reads), stall and flush
    localparam int TimeoutCycles =
        2 * (12 + (AluRounds * 23 + 4) * 2 + 12 + 32 * 2 + MdRuns * (40 + 6) + 80);

    logic        Clk;
    logic        rst;
    logic        flush;
    logic        memStall;
    decodedOp_t  dec;
    fwdSrc_t     memFwd;
    execResult_t res;
    logic        busy;

    int          errors;
    int          checks;
    int          cycles;
    bit          endReported;
    logic [31:0] modelHi;
    logic [31:0] modelLo;
    execOp_e     aluOps [23] = '{opAdd, opAddu, opSub, opSubu, opAnd, opOr, opXor, opNor,
                                 opSlt, opSltu, opSll, opSrl, opSra, opSllv, opSrlv, opSrav,
                                 opAddi, opAddiu, opAndi, opOri, opXori, opSlti, opLui};
    execOp_e     memOps [8] = '{opLb, opLbu, opLh, opLhu, opLw, opSb, opSh, opSw};

    execStage u_execStage (
        .Clk      (Clk),
        .rst      (rst),
        .flush    (flush),
        .memStall (memStall),
        .dec      (dec),
        .memFwd   (memFwd),
        .res      (res),
        .busy     (busy)
    );

    initial begin
        Clk = 1'b0;
        forever #2 Clk = ~Clk;
    end

    always @(posedge Clk) begin
        cycles <= cycles + 1;
        if (cycles >= TimeoutCycles) begin
            endReported = 1'b1;
            $display("timeout: run did not finish within %0d cycles", TimeoutCycles);
            $display("Testbench failed");
            $finish;
        end
    end

    final begin
        if (!endReported)
            $display("Testbench failed");   // run ended before the summary line
    end

    task automatic checkResult(string name, execResult_t exp, execResult_t act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("FAILED %s expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic checkCtl(string name, memCtl_t exp, memCtl_t act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("FAILED %s expected %b actual %b", name, exp, act);
        end
    endtask

    task automatic checkData(string name, logic [31:0] exp, logic [31:0] act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("FAILED %s expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic reportProblem(string msg);
        errors++;
        $display("%s", msg);
    endtask

    function automatic decodedOp_t makeDec(execOp_e op, logic [4:0] rsN, logic [31:0] rsD,
                                           logic [4:0] rtN, logic [31:0] rtD,
                                           logic [15:0] imm, logic [4:0] dest);
        decodedOp_t d;
        d.valid    = 1'b1;
        d.pc       = $urandom & 32'hffff_fffc;
        d.op       = op;
        d.rsNum    = rsN;
        d.rtNum    = rtN;
        d.rsData   = rsD;
        d.rtData   = rtD;
        d.shamt    = 5'($urandom);
        d.imm16    = imm;
        d.destReg  = dest;
        d.regWrite = !(op inside {opSb, opSh, opSw});
        return d;
    endfunction

    function automatic logic [31:0] aluRef(decodedOp_t d, output logic ovf);
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] se;
        longint      s;
        a   = d.rsData;
        b   = d.rtData;
        se  = {{16{d.imm16[15]}}, d.imm16};
        ovf = 1'b0;
        case (d.op)
            opAdd, opSub, opAddi: begin
                if (d.op == opAdd)      s = longint'($signed(a)) + longint'($signed(b));
                else if (d.op == opSub) s = longint'($signed(a)) - longint'($signed(b));
                else                    s = longint'($signed(a)) + longint'($signed(se));
                ovf = (s > 64'sd2147483647) || (s < -64'sd2147483648);
                return s[31:0];
            end
            opAddu:  return a + b;
            opSubu:  return a - b;
            opAnd:   return a & b;
            opOr:    return a | b;
            opXor:   return a ^ b;
            opNor:   return ~(a | b);
            opSlt:   return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            opSltu:  return (a < b) ? 32'd1 : 32'd0;
            opSll:   return b << d.shamt;
            opSrl:   return b >> d.shamt;
            opSra:   return $signed(b) >>> d.shamt;
            opSllv:  return b << a[4:0];
            opSrlv:  return b >> a[4:0];
            opSrav:  return $signed(b) >>> a[4:0];
            opAddiu: return a + se;
            opAndi:  return a & {16'h0, d.imm16};
            opOri:   return a | {16'h0, d.imm16};
            opXori:  return a ^ {16'h0, d.imm16};
            opSlti:  return ($signed(a) < $signed(se)) ? 32'd1 : 32'd0;
            opLui:   return {d.imm16, 16'h0};
            default: return 32'h0;
        endcase
    endfunction

    function automatic execResult_t expectAlu(decodedOp_t d);
        execResult_t e;
        logic        ovf;
        e           = '0;
        e.valid     = 1'b1;
        e.pc        = d.pc;
        e.op        = d.op;
        e.storeData = d.rtData;
        e.regWrite  = d.regWrite;
        e.ready     = 1'b1;
        e.destReg   = d.destReg;
        e.data      = aluRef(d, ovf);
        e.overflow  = ovf;
        return e;
    endfunction

    // an op is taken on the edge after a cycle with busy and memStall low
    task automatic waitAccept();
        do @(negedge Clk); while (busy || memStall);
        @(posedge Clk);
    endtask

    task automatic runOne(decodedOp_t d, output execResult_t got);
        dec <= d;
        waitAccept();
        dec.valid <= 1'b0;
        @(negedge Clk);
        got = res;
        @(posedge Clk);
    endtask

    task automatic readHiLo(string name);
        execResult_t got;
        runOne(makeDec(opMfhi, 0, 0, 0, 0, 0, 5'd3), got);
        checkData({name, " hi"}, modelHi, got.data);
        runOne(makeDec(opMflo, 0, 0, 0, 0, 0, 5'd4), got);
        checkData({name, " lo"}, modelLo, got.data);
    endtask

    task automatic aluTest();
        decodedOp_t  d;
        execResult_t got;
        decodedOp_t  edge4 [4];
        edge4[0] = makeDec(opAdd, 0, 32'h7fff_ffff, 0, 32'h1, 0, 5'd2);
        edge4[1] = makeDec(opSub, 0, 32'h8000_0000, 0, 32'h1, 0, 5'd2);
        edge4[2] = makeDec(opAddi, 0, 32'h7fff_fff0, 0, 0, 16'h0010, 5'd2);
        edge4[3] = makeDec(opAddu, 0, 32'h7fff_ffff, 0, 32'h1, 0, 5'd2);
        for (int i = 0; i < 4; i++) begin
            runOne(edge4[i], got);
            checkResult("alu overflow edge", expectAlu(edge4[i]), got);
        end
        for (int r = 0; r < AluRounds; r++) begin
            foreach (aluOps[k]) begin
                d = makeDec(aluOps[k], 0, $urandom, 0, $urandom, 16'($urandom),
                            5'($urandom % 31 + 1));
                runOne(d, got);
                checkResult($sformatf("alu %s", aluOps[k].name()), expectAlu(d), got);
            end
        end
    endtask

    task automatic forwardTest();
        decodedOp_t  p;
        decodedOp_t  p0;
        execResult_t got;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] c;
        logic [31:0] m;
        a  = $urandom;
        b  = $urandom;
        c  = $urandom;
        m  = $urandom;
        p  = makeDec(opAddu, 0, a, 0, b, 0, 5'd5);
        p0 = makeDec(opAddu, 0, a, 0, b, 0, 5'd0);
        dec <= p;
        waitAccept();   // consumer issued right behind the producer
        runOne(makeDec(opAddu, 5'd5, 32'hdead_beef, 0, c, 0, 5'd6), got);
        checkData("fwd from execute", a + b + c, got.data);
        memFwd <= '{regWrite: 1'b1, ready: 1'b1, regNum: 5'd7, data: m};
        runOne(makeDec(opOr, 5'd7, 32'h1234_5678, 0, c, 0, 5'd6), got);
        checkData("fwd from memory", m | c, got.data);
        memFwd.ready <= 1'b0;   // pending load
        runOne(makeDec(opOr, 5'd7, 32'h1234_5678, 0, c, 0, 5'd6), got);
        checkData("fwd memory not ready", 32'h1234_5678 | c, got.data);
        memFwd <= '{regWrite: 1'b1, ready: 1'b1, regNum: 5'd5, data: m};
        dec <= p;
        waitAccept();
        runOne(makeDec(opAddu, 5'd5, 32'h0, 0, c, 0, 5'd6), got);
        checkData("fwd execute before memory", a + b + c, got.data);
        memFwd.regNum <= 5'd0;
        dec <= p0;
        waitAccept();
        runOne(makeDec(opAddu, 5'd0, 32'h55, 0, c, 0, 5'd6), got);
        checkData("fwd register zero", 32'h55 + c, got.data);
        memFwd <= '0;
    endtask

    task automatic memTest();
        decodedOp_t  d;
        execResult_t got;
        memCtl_t     exp;
        memCtl_t     act;
        logic        isLoad;
        logic [31:0] base;
        logic [15:0] imm;
        foreach (memOps[k]) begin
            for (int off = 0; off < 4; off++) begin
                base = $urandom & 32'hffff_fffc;
                imm  = (16'($urandom) & 16'h0ffc) | 16'(off);
                d    = makeDec(memOps[k], 0, base, 0, $urandom, imm, 5'd9);
                runOne(d, got);
                isLoad        = memOps[k] inside {opLb, opLbu, opLh, opLhu, opLw};
                exp.memRead   = isLoad;
                exp.memWrite  = !isLoad;
                exp.unaligned = (memOps[k] inside {opLw, opSw} && off != 0)
                             || (memOps[k] inside {opLh, opLhu, opSh} && off % 2 == 1);
                exp.byteEn    = 4'b0000;
                if (!exp.unaligned) begin
                    if (memOps[k] == opSw) exp.byteEn = 4'b1111;
                    if (memOps[k] == opSh) exp.byteEn = 4'b0011 << off;
                    if (memOps[k] == opSb) exp.byteEn = 4'b0001 << off;
                end
                act = '{got.byteEn, got.memRead, got.memWrite, got.unaligned};
                checkCtl($sformatf("mem %s ctl", memOps[k].name()), exp, act);
                checkData("mem address", base + {{16{imm[15]}}, imm}, got.data);
                checkData("mem store data", d.rtData, got.storeData);
                checkData("mem ready", 32'(!isLoad), 32'(got.ready));
            end
        end
    endtask

    task automatic mdModel(execOp_e op, logic [31:0] a, logic [31:0] b);
        logic [63:0] p;
        logic [31:0] qa;
        logic [31:0] qb;
        if (op inside {opMult, opMul}) begin
            p = longint'($signed(a)) * longint'($signed(b));
            {modelHi, modelLo} = p;
        end else if (op == opMultu) begin
            p = {32'h0, a} * {32'h0, b};
            {modelHi, modelLo} = p;
        end else if (b != 0) begin
            qa = (op == opDiv && a[31]) ? -a : a;
            qb = (op == opDiv && b[31]) ? -b : b;
            modelLo = (op == opDiv && (a[31] ^ b[31])) ? -(qa / qb) : qa / qb;
            modelHi = (op == opDiv && a[31]) ? -(qa % qb) : qa % qb;
        end
    endtask

    task automatic mdRun(execOp_e op, logic [31:0] a, logic [31:0] b);
        decodedOp_t  d;
        execResult_t exp;
        d = makeDec(op, 0, a, 0, b, 0, 5'd8);
        mdModel(op, a, b);
        exp          = expectAlu(d);
        exp.regWrite = (op == opMul) && d.regWrite;
        exp.data     = modelLo;
        dec <= d;
        waitAccept();
        dec <= makeDec(opMfhi, 0, 0, 0, 0, 0, 5'd3);   // held by decode while busy
        @(negedge Clk);
        if (!busy)
            reportProblem($sformatf("busy did not rise for %s", op.name()));
        while (busy) begin
            if (res.valid)
                reportProblem("a result appeared while the stage was busy");
            @(negedge Clk);
        end
        checkResult($sformatf("md %s", op.name()), exp, res);
        @(posedge Clk);
        dec <= makeDec(opMflo, 0, 0, 0, 0, 0, 5'd4);
        @(negedge Clk);
        checkData($sformatf("md %s hi", op.name()), modelHi, res.data);
        @(posedge Clk);
        dec.valid <= 1'b0;
        @(negedge Clk);
        checkData($sformatf("md %s lo", op.name()), modelLo, res.data);
        @(posedge Clk);
    endtask

    task automatic mulDivTest();
        for (int i = 0; i < 3; i++) begin
            mdRun(opMult, $urandom, $urandom);
            mdRun(opMultu, $urandom, $urandom);
            mdRun(opDiv, $urandom, $urandom % 5000 + 1);
            mdRun(opDivu, $urandom, $urandom);
        end
        mdRun(opMul, $urandom, $urandom);
        mdRun(opDiv, -32'sd7, 32'd2);
        mdRun(opDiv, $urandom, 32'd0);   // hi/lo stay put
        mdRun(opDivu, $urandom, 32'd0);
    endtask

    task automatic stallFlushTest();
        decodedOp_t  da;
        decodedOp_t  db;
        execResult_t got;
        da = makeDec(opXor, 0, $urandom, 0, $urandom, 0, 5'd10);
        db = makeDec(opSubu, 0, $urandom, 0, $urandom, 0, 5'd11);
        dec <= da;
        waitAccept();
        dec      <= db;
        memStall <= 1'b1;
        repeat (4) begin
            @(negedge Clk);
            checkResult("stall hold", expectAlu(da), res);
        end
        @(posedge Clk);
        memStall <= 1'b0;
        waitAccept();
        dec.valid <= 1'b0;
        @(negedge Clk);
        checkResult("after stall", expectAlu(db), res);
        @(posedge Clk);
        dec <= da;
        waitAccept();
        dec   <= db;   // valid op waiting on the flush edge
        flush <= 1'b1;
        @(posedge Clk);
        dec.valid <= 1'b0;
        flush     <= 1'b0;
        @(negedge Clk);
        if (res.valid)
            reportProblem("result still valid after a flush");
        @(posedge Clk);
        dec <= makeDec(opDiv, 0, $urandom, 0, 32'd3, 0, 5'd12);
        waitAccept();
        dec.valid <= 1'b0;
        repeat (10) @(posedge Clk);
        flush <= 1'b1;
        @(posedge Clk);
        flush <= 1'b0;
        @(negedge Clk);
        if (busy || res.valid)
            reportProblem("stage still busy or valid after flushing a divide");
        @(posedge Clk);
        readHiLo("hi/lo kept after flush");
    endtask

    initial begin
        void'($urandom(2));
        errors      = 0;
        checks      = 0;
        cycles      = 0;
        endReported = 1'b0;
        modelHi     = '0;
        modelLo     = '0;
        rst         = 1'b1;
        flush       = 1'b0;
        memStall    = 1'b0;
        dec         = '0;
        memFwd      = '0;
        repeat (10) @(posedge Clk);
        rst <= 1'b0;
        @(negedge Clk);
        if (res.valid || busy)
            reportProblem("res.valid or busy set right after reset");
        @(posedge Clk);
        aluTest();
        forwardTest();
        memTest();
        mulDivTest();
        stallFlushTest();
        endReported = 1'b1;
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0)
            $display("Testbench passed");
        else
            $display("Testbench failed");
        $finish;
    end

endmodule

// ==== logic/execAlu.sv ====
`timescale 1ns/1ps
`include "exec_consts.svh"

module execAlu
    import exec_pkg::*;
(
    input  execOp_e               op,
    input  logic [`EXEC_XLEN-1:0] srcA,
    input  logic [`EXEC_XLEN-1:0] srcB,
    input  logic [`EXEC_XLEN-1:0] pc,
    input  logic [4:0]            shamt,
    input  logic [15:0]           imm16,
    input  logic [`EXEC_XLEN-1:0] hi,
    input  logic [`EXEC_XLEN-1:0] lo,
    output logic [`EXEC_XLEN-1:0] result,
    output logic                  overflow
);
    localparam int Msb = `EXEC_XLEN - 1;

    logic [`EXEC_XLEN-1:0] immSext;
    logic [`EXEC_XLEN-1:0] immZext;
    logic [`EXEC_XLEN-1:0] sum;
    logic [`EXEC_XLEN-1:0] diff;
    logic [`EXEC_XLEN-1:0] sumImm;
    logic                  addWrap;
    logic                  subWrap;
    logic                  addiWrap;

    assign immSext = {{(`EXEC_XLEN-16){imm16[15]}}, imm16};
    assign immZext = {{(`EXEC_XLEN-16){1'b0}}, imm16};
    assign sum     = srcA + srcB;
    assign diff    = srcA - srcB;
    assign sumImm  = srcA + immSext;   // also the load/store address

    // signed wrap: operands agree in sign, result does not
    assign addWrap  = (srcA[Msb] == srcB[Msb]) && (sum[Msb] != srcA[Msb]);
    assign subWrap  = (srcA[Msb] != srcB[Msb]) && (diff[Msb] != srcA[Msb]);
    assign addiWrap = (srcA[Msb] == immSext[Msb]) && (sumImm[Msb] != srcA[Msb]);

    always_comb begin
        result = '0;
        case (op)
            opAdd, opAddu:   result = sum;
            opSub, opSubu:   result = diff;
            opAnd:           result = srcA & srcB;
            opOr:            result = srcA | srcB;
            opXor:           result = srcA ^ srcB;
            opNor:           result = ~(srcA | srcB);
            opSlt:           result = {{Msb{1'b0}}, $signed(srcA) < $signed(srcB)};
            opSltu:          result = {{Msb{1'b0}}, srcA < srcB};
            opSll:           result = srcB << shamt;
            opSrl:           result = srcB >> shamt;
            opSra:           result = $signed(srcB) >>> shamt;
            opSllv:          result = srcB << srcA[4:0];
            opSrlv:          result = srcB >> srcA[4:0];
            opSrav:          result = $signed(srcB) >>> srcA[4:0];
            opAddi, opAddiu: result = sumImm;
            opAndi:          result = srcA & immZext;
            opOri:           result = srcA | immZext;
            opXori:          result = srcA ^ immZext;
            opSlti:          result = {{Msb{1'b0}}, $signed(srcA) < $signed(immSext)};
            opLui:           result = {imm16, {(`EXEC_XLEN-16){1'b0}}};
            opMfhi:          result = hi;
            opMflo:          result = lo;
            opLb, opLbu, opLh, opLhu, opLw,
            opSb, opSh, opSw: result = sumImm;
            opNop:           result = pc;   // bubble keeps its pc for trace
            default:         result = '0;   // multi-cycle ops take lo later
        endcase
    end

    always_comb begin
        case (op)
            opAdd:   overflow = addWrap;
            opSub:   overflow = subWrap;
            opAddi:  overflow = addiWrap;
            default: overflow = 1'b0;
        endcase
    end

endmodule

// ==== logic/execMemLane.sv ====
`timescale 1ns/1ps

module execMemLane
    import exec_pkg::*;
(
    input  execOp_e    op,
    input  logic [1:0] addrLow,
    output memCtl_t    ctl
);
    logic       isLoad;
    logic       isStore;
    logic       misaligned;
    logic [3:0] lanes;

    always_comb begin
        isLoad     = 1'b0;
        isStore    = 1'b0;
        misaligned = 1'b0;
        lanes      = 4'b0000;
        case (op)
            opLb, opLbu: isLoad = 1'b1;
            opLh, opLhu: begin
                isLoad     = 1'b1;
                misaligned = addrLow[0];
            end
            opLw: begin
                isLoad     = 1'b1;
                misaligned = |addrLow;
            end
            opSb: begin
                isStore = 1'b1;
                lanes   = 4'b0001 << addrLow;
            end
            opSh: begin
                isStore    = 1'b1;
                misaligned = addrLow[0];
                lanes      = 4'b0011 << addrLow;
            end
            opSw: begin
                isStore    = 1'b1;
                misaligned = |addrLow;
                lanes      = 4'b1111;
            end
            default: ;
        endcase
    end

    assign ctl.byteEn    = misaligned ? 4'b0000 : lanes;   // no write on a bad store
    assign ctl.memRead   = isLoad;
    assign ctl.memWrite  = isStore;
    assign ctl.unaligned = misaligned;

endmodule

// ==== logic/execMulDiv.sv ====
`timescale 1ns/1ps
`include "exec_consts.svh"

module execMulDiv
    import exec_pkg::*;
(
    input  logic                  Clk,
    input  logic                  rst,
    input  logic                  abort,
    input  logic                  start,
    input  execOp_e               op,
    input  logic [`EXEC_XLEN-1:0] srcA,
    input  logic [`EXEC_XLEN-1:0] srcB,
    output logic [`EXEC_XLEN-1:0] hi,
    output logic [`EXEC_XLEN-1:0] lo,
    output logic                  busy,
    output logic                  done
);
    localparam int Xlen = `EXEC_XLEN;
    localparam int CntW = $clog2(`EXEC_DIV_CYCLES + 1);

    mdState_e              state;
    logic [CntW-1:0]       cnt;
    logic                  launch;
    logic                  isDiv;
    logic                  signedOp;
    logic                  lastMul;
    logic                  lastDiv;
    logic [Xlen-1:0]       absA;
    logic [Xlen-1:0]       absB;
    logic [Xlen-1:0]       opA;      // multiplicand; unused by divide
    logic [Xlen-1:0]       opB;      // multiplier or divisor magnitude
    logic                  isSigned;
    logic                  negQuo;
    logic                  negRem;
    logic                  divZero;
    logic signed [2*Xlen-1:0] prodFull;
    logic [2*Xlen-1:0]     prodReg;
    logic [Xlen-1:0]       rem;
    logic [Xlen-1:0]       quo;      // dividend shifts out as quotient shifts in
    logic [Xlen:0]         shifted;
    logic [Xlen+1:0]       trial;

    assign launch   = start && (state == mdIdle || state == mdDone);
    assign isDiv    = (op == opDiv) || (op == opDivu);
    assign signedOp = (op == opMult) || (op == opDiv) || (op == opMul);
    assign absA     = (signedOp && srcA[Xlen-1]) ? -srcA : srcA;
    assign absB     = (signedOp && srcB[Xlen-1]) ? -srcB : srcB;
    assign lastMul  = cnt == CntW'(`EXEC_MUL_CYCLES - 1);
    assign lastDiv  = cnt == CntW'(`EXEC_DIV_CYCLES - 1);

    assign prodFull = $signed({{Xlen{isSigned & opA[Xlen-1]}}, opA})
                    * $signed({{Xlen{isSigned & opB[Xlen-1]}}, opB});
    assign shifted  = {rem, quo[Xlen-1]};
    assign trial    = {1'b0, shifted} - {2'b0, opB};

    always_ff @(posedge Clk) begin
        if (rst || abort) begin
            state <= mdIdle;
            cnt   <= '0;
        end else begin
            case (state)
                mdIdle, mdDone: begin
                    if (start) begin
                        state <= isDiv ? mdDivRun : mdMulRun;
                        cnt   <= '0;
                    end
                end
                mdMulRun: begin
                    cnt <= cnt + 1'b1;
                    if (lastMul) state <= mdDone;
                end
                mdDivRun: begin
                    cnt <= cnt + 1'b1;
                    if (lastDiv) state <= mdDone;
                end
                default: state <= mdIdle;
            endcase
        end
    end

    always_ff @(posedge Clk) begin
        if (launch) begin
            opA      <= srcA;
            opB      <= isDiv ? absB : srcB;
            isSigned <= signedOp;
            negQuo   <= signedOp && (srcA[Xlen-1] ^ srcB[Xlen-1]);
            negRem   <= signedOp && srcA[Xlen-1];   // remainder follows the dividend
            divZero  <= srcB == '0;
            rem      <= '0;
            quo      <= absA;
        end else if (state == mdMulRun) begin
            prodReg <= prodFull;
        end else if (state == mdDivRun && !lastDiv) begin
            quo <= {quo[Xlen-2:0], ~trial[Xlen+1]};
            rem <= trial[Xlen+1] ? shifted[Xlen-1:0] : trial[Xlen-1:0];
        end
    end

    // hi/lo commit on the edge into mdDone
    always_ff @(posedge Clk) begin
        if (rst) begin
            hi <= '0;
            lo <= '0;
        end else if (!abort) begin
            if (state == mdMulRun && lastMul) begin
                {hi, lo} <= prodReg;
            end else if (state == mdDivRun && lastDiv && !divZero) begin
                hi <= negRem ? -rem : rem;
                lo <= negQuo ? -quo : quo;
            end
        end
    end

    assign busy = (state == mdMulRun) || (state == mdDivRun);
    assign done = state == mdDone;

endmodule

// ==== logic/execStage.sv ====
`timescale 1ns/1ps
`include "exec_consts.svh"

module execStage
    import exec_pkg::*;
(
    input  logic        Clk,
    input  logic        rst,
    input  logic        flush,
    input  logic        memStall,
    input  decodedOp_t  dec,
    input  fwdSrc_t     memFwd,
    output execResult_t res,
    output logic        busy
);
    logic [`EXEC_XLEN-1:0] rsVal;
    logic [`EXEC_XLEN-1:0] rtVal;
    logic [`EXEC_XLEN-1:0] aluResult;
    logic                  aluOverflow;
    logic [`EXEC_XLEN-1:0] mdHi;
    logic [`EXEC_XLEN-1:0] mdLo;
    logic                  mdBusy;
    logic                  mdDone;
    logic                  mdStart;
    logic                  parked;
    logic                  accept;
    logic                  isMulti;
    memCtl_t               memCtl;
    execResult_t           issued;
    execResult_t           parkRes;
    execResult_t           finished;

    // execute result first, then memory stage, then the register file value
    function automatic logic [`EXEC_XLEN-1:0] pickOperand(
        input logic [`EXEC_REGW-1:0] num,
        input logic [`EXEC_XLEN-1:0] decVal,
        input execResult_t           exRes,
        input fwdSrc_t               memSrc
    );
        logic exHit;
        logic memHit;
        exHit  = exRes.valid && exRes.regWrite && exRes.ready && exRes.destReg == num;
        memHit = memSrc.regWrite && memSrc.ready && memSrc.regNum == num;
        if (num == '0)
            return decVal;
        else if (exHit)
            return exRes.data;
        else if (memHit)
            return memSrc.data;
        else
            return decVal;
    endfunction

    assign rsVal = pickOperand(dec.rsNum, dec.rsData, res, memFwd);
    assign rtVal = pickOperand(dec.rtNum, dec.rtData, res, memFwd);

    assign isMulti = dec.op inside {opMult, opMultu, opDiv, opDivu, opMul};
    assign accept  = dec.valid && !busy && !memStall && !flush;
    assign mdStart = accept && isMulti;
    assign busy    = parked | mdBusy;

    execAlu u_execAlu (
        .op       (dec.op),
        .srcA     (rsVal),
        .srcB     (rtVal),
        .pc       (dec.pc),
        .shamt    (dec.shamt),
        .imm16    (dec.imm16),
        .hi       (mdHi),
        .lo       (mdLo),
        .result   (aluResult),
        .overflow (aluOverflow)
    );

    execMulDiv u_execMulDiv (
        .Clk   (Clk),
        .rst   (rst),
        .abort (flush),
        .start (mdStart),
        .op    (dec.op),
        .srcA  (rsVal),
        .srcB  (rtVal),
        .hi    (mdHi),
        .lo    (mdLo),
        .busy  (mdBusy),
        .done  (mdDone)
    );

    execMemLane u_execMemLane (
        .op      (dec.op),
        .addrLow (aluResult[1:0]),
        .ctl     (memCtl)
    );

    always_comb begin
        issued.valid     = 1'b1;
        issued.pc        = dec.pc;
        issued.op        = dec.op;
        issued.data      = aluResult;
        issued.storeData = rtVal;
        issued.byteEn    = memCtl.byteEn;
        issued.memRead   = memCtl.memRead;
        issued.memWrite  = memCtl.memWrite;
        issued.regWrite  = dec.regWrite && (!isMulti || dec.op == opMul);  // only mul writes rd
        issued.ready     = !memCtl.memRead;   // load data arrives in mem stage
        issued.destReg   = dec.destReg;
        issued.overflow  = aluOverflow;
        issued.unaligned = memCtl.unaligned;
    end

    always_comb begin
        finished      = parkRes;
        finished.data = mdLo;
    end

    always_ff @(posedge Clk) begin
        if (mdStart)
            parkRes <= issued;
    end

    always_ff @(posedge Clk) begin
        if (rst || flush) begin
            res    <= '0;
            parked <= 1'b0;
        end else if (!memStall) begin
            if (parked && mdDone) begin
                res    <= finished;
                parked <= 1'b0;
            end else if (mdStart) begin
                parked    <= 1'b1;
                res.valid <= 1'b0;
            end else if (accept) begin
                res <= issued;
            end else begin
                res.valid <= 1'b0;   // bubble
            end
        end
    end

endmodule

// ==== logic/exec_consts.svh ====
`ifndef EXEC_CONSTS_SVH
`define EXEC_CONSTS_SVH

// datapath width and register-number width
`define EXEC_XLEN 32
`define EXEC_REGW 5

// cycles the multi-cycle unit spends in each run state
`define EXEC_MUL_CYCLES 4
`define EXEC_DIV_CYCLES 33   // 32 restoring steps plus sign fix-up

`endif

// ==== logic/exec_pkg.sv ====
`include "exec_consts.svh"

package exec_pkg;

    typedef enum logic [5:0] {
        opNop = 6'd0,
        opAdd, opAddu, opSub, opSubu, opAnd, opOr, opXor, opNor, opSlt, opSltu,
        opSll, opSrl, opSra, opSllv, opSrlv, opSrav,
        opAddi, opAddiu, opAndi, opOri, opXori, opSlti, opLui,
        opMult, opMultu, opDiv, opDivu, opMul,
        opMfhi, opMflo,
        opLb, opLbu, opLh, opLhu, opLw,
        opSb, opSh, opSw
    } execOp_e;

    typedef enum logic [1:0] {
        mdIdle,
        mdMulRun,
        mdDivRun,
        mdDone
    } mdState_e;

    // one decoded instruction from the decode stage
    typedef struct packed {
        logic                  valid;
        logic [`EXEC_XLEN-1:0] pc;
        execOp_e               op;
        logic [`EXEC_REGW-1:0] rsNum;
        logic [`EXEC_REGW-1:0] rtNum;
        logic [`EXEC_XLEN-1:0] rsData;
        logic [`EXEC_XLEN-1:0] rtData;
        logic [4:0]            shamt;
        logic [15:0]           imm16;
        logic [`EXEC_REGW-1:0] destReg;
        logic                  regWrite;
    } decodedOp_t;

    typedef struct packed {
        logic                  regWrite;
        logic                  ready;    // data is final, not a pending load
        logic [`EXEC_REGW-1:0] regNum;
        logic [`EXEC_XLEN-1:0] data;
    } fwdSrc_t;

    typedef struct packed {
        logic                  valid;
        logic [`EXEC_XLEN-1:0] pc;
        execOp_e               op;
        logic [`EXEC_XLEN-1:0] data;       // alu result or effective address
        logic [`EXEC_XLEN-1:0] storeData;
        logic [3:0]            byteEn;
        logic                  memRead;
        logic                  memWrite;
        logic                  regWrite;
        logic                  ready;
        logic [`EXEC_REGW-1:0] destReg;
        logic                  overflow;
        logic                  unaligned;
    } execResult_t;

    typedef struct packed {
        logic [3:0] byteEn;
        logic       memRead;
        logic       memWrite;
        logic       unaligned;
    } memCtl_t;

endpackage

// ==== run.sh ====
#!/bin/sh
# build and run the execute stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    --top-module execStage_tb -Mdir obj_dir -f sim.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/VexecStage_tb)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qx "Testbench passed"; then
    exit 0
fi
exit 1

// ==== sim.f ====
+incdir+logic
logic/exec_pkg.sv
logic/execAlu.sv
logic/execMulDiv.sv
logic/execMemLane.sv
logic/execStage.sv
bench/execStage_chk.sv
bench/execStage_tb.sv
